//--- verilog/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  localparam int AXI_ADDR_W = 16;
  localparam int AXI_DATA_W = 32;
  // one strobe per byte lane
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [1:0]            axi_resp_t;

  // only OKAY is ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

  ////////////////////////////////////////
  // channel machines
  ////////////////////////////////////////

  // write side: accept, req/ack with the store, then B
  typedef enum logic [1:0] {wr_idle, wr_request, wr_wait_release, wr_respond} wr_state_t;

  // read side: accept, req/ack with the store, then R
  typedef enum logic [1:0] {rd_idle, rd_request, rd_wait_release, rd_respond} rd_state_t;

endpackage

`default_nettype wire

//--- verilog/text_map_pkg.sv
`default_nettype none

package text_map_pkg;

  ////////////////////////////////////////
  // memory map of the text controller
  ////////////////////////////////////////

  // bit 15 high selects the palette, low selects vram
  localparam int PAL_SELECT_BIT = 15;

  // word addressed, byte offset sits below this bit
  localparam int WORD_LSB = 2;

  // vram word index comes from addr[11:2]
  // bits 12 to 14 are not decoded and alias
  localparam int VRAM_INDEX_W = 10;

  // palette index comes from addr[4:2]
  localparam int PAL_INDEX_W = 3;
  localparam int PAL_ENTRIES = 1 << PAL_INDEX_W;

  // one vram word holds the character cells of a column pair
  typedef logic [VRAM_INDEX_W-1:0] vram_index_t;

  // eight colour registers
  typedef logic [PAL_INDEX_W-1:0] pal_index_t;

endpackage

`default_nettype wire

//--- verilog/axi_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel
  import axi_lite_pkg::*;
(
  input  wire             S_AXI_ACLK,
  input  wire             S_AXI_ARESETN,
  // AW and W channels
  input  wire  axi_addr_t S_AXI_AWADDR,
  input  wire             S_AXI_AWVALID,
  output logic            S_AXI_AWREADY,
  input  wire  axi_data_t S_AXI_WDATA,
  input  wire  axi_strb_t S_AXI_WSTRB,
  input  wire             S_AXI_WVALID,
  output logic            S_AXI_WREADY,
  // B channel
  output axi_resp_t       S_AXI_BRESP,
  output logic            S_AXI_BVALID,
  input  wire             S_AXI_BREADY,
  // four-phase request to the store
  output logic            wr_req,
  output axi_addr_t       wr_addr,
  output axi_data_t       wr_data,
  output axi_strb_t       wr_strb,
  input  wire             wr_ack
);

  wr_state_t state;

  // every write completes without error
  assign S_AXI_BRESP = RESP_OKAY;

  ////////////////////////////////////////
  // channel state machine
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state         <= wr_idle;
      S_AXI_AWREADY <= 1'b0;
      S_AXI_WREADY  <= 1'b0;
      S_AXI_BVALID  <= 1'b0;
      wr_req        <= 1'b0;
    end
    else
    begin
      case (state)
        wr_idle:
        begin
          if (S_AXI_AWREADY)
          begin
            // end of the ready pulse, AW and W handshake on this edge
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            wr_req        <= 1'b1;
            state         <= wr_request;
          end
          else if (S_AXI_AWVALID && S_AXI_WVALID)
          begin
            // both halves present, pulse ready on both
            S_AXI_AWREADY <= 1'b1;
            S_AXI_WREADY  <= 1'b1;
          end
        end
        wr_request:
        begin
          // store has merged the word
          if (wr_ack)
          begin
            wr_req <= 1'b0;
            state  <= wr_wait_release;
          end
        end
        wr_wait_release:
        begin
          // ack released, exchange done
          if (!wr_ack)
          begin
            S_AXI_BVALID <= 1'b1;
            state        <= wr_respond;
          end
        end
        wr_respond:
        begin
          // hold B until the master takes it
          if (S_AXI_BREADY)
          begin
            S_AXI_BVALID <= 1'b0;
            state        <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // payload taken in the same edge as the AW/W handshake
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == wr_idle && S_AXI_AWREADY)
    begin
      wr_addr <= S_AXI_AWADDR;
      wr_data <= S_AXI_WDATA;
      wr_strb <= S_AXI_WSTRB;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // store sees one payload for the whole exchange
  a_wr_payload_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (wr_req || wr_ack) && $past(wr_req || wr_ack) |-> $stable({wr_addr, wr_data, wr_strb}))
    else $error("write payload changed during req/ack");

  // B may not be withdrawn before BREADY
  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else $error("BVALID dropped without BREADY");

endmodule

`default_nettype wire

//--- verilog/axi_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_channel
  import axi_lite_pkg::*;
(
  input  wire             S_AXI_ACLK,
  input  wire             S_AXI_ARESETN,
  // AR channel
  input  wire  axi_addr_t S_AXI_ARADDR,
  input  wire             S_AXI_ARVALID,
  output logic            S_AXI_ARREADY,
  // R channel
  output axi_data_t       S_AXI_RDATA,
  output axi_resp_t       S_AXI_RRESP,
  output logic            S_AXI_RVALID,
  input  wire             S_AXI_RREADY,
  // fetch from the store
  output logic            rd_req,
  output axi_addr_t       rd_addr,
  input  wire             rd_ack,
  input  wire  axi_data_t rd_data
);

  rd_state_t state;

  // reads never fail
  assign S_AXI_RRESP = RESP_OKAY;

  ////////////////////////////////////////
  // channel state machine
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state         <= rd_idle;
      S_AXI_ARREADY <= 1'b0;
      S_AXI_RVALID  <= 1'b0;
      rd_req        <= 1'b0;
    end
    else
    begin
      case (state)
        rd_idle:
        begin
          // one-cycle ready pulse, then go fetch
          if (S_AXI_ARREADY)
          begin
            S_AXI_ARREADY <= 1'b0;
            rd_req        <= 1'b1;
            state         <= rd_request;
          end
          else if (S_AXI_ARVALID)
            S_AXI_ARREADY <= 1'b1;
        end
        rd_request:
        begin
          if (rd_ack)
          begin
            rd_req <= 1'b0;
            state  <= rd_wait_release;
          end
        end
        rd_wait_release:
        begin
          if (!rd_ack)
          begin
            S_AXI_RVALID <= 1'b1;
            state        <= rd_respond;
          end
        end
        rd_respond:
        begin
          if (S_AXI_RREADY)
          begin
            S_AXI_RVALID <= 1'b0;
            state        <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

  // address at the AR handshake, word while ack is up
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == rd_idle && S_AXI_ARREADY)
      rd_addr <= S_AXI_ARADDR;
    if (state == rd_request && rd_ack)
      S_AXI_RDATA <= rd_data;
  end

  // R beat frozen under back-pressure
  a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
    else $error("R beat changed before RREADY");

endmodule

`default_nettype wire

//--- verilog/text_vram_store.sv
`timescale 1ns/1ps
`default_nettype none

module text_vram_store
  import axi_lite_pkg::*, text_map_pkg::*;
#(
  parameter int VRAM_DEPTH = 1024
)
(
  input  wire             S_AXI_ACLK,
  input  wire             S_AXI_ARESETN,
  // write exchange
  input  wire             wr_req,
  input  wire  axi_addr_t wr_addr,
  input  wire  axi_data_t wr_data,
  input  wire  axi_strb_t wr_strb,
  output logic            wr_ack,
  // read exchange
  input  wire             rd_req,
  input  wire  axi_addr_t rd_addr,
  output logic            rd_ack,
  output axi_data_t       rd_data
);

  localparam int VRAM_AW = $clog2(VRAM_DEPTH);

  axi_data_t   vram [VRAM_DEPTH];
  axi_data_t   palette [PAL_ENTRIES];

  vram_index_t wr_vram_idx;
  vram_index_t rd_vram_idx;
  pal_index_t  wr_pal_idx;
  pal_index_t  rd_pal_idx;
  logic        wr_pal;
  logic        rd_pal;
  logic        wr_fire;
  logic        rd_fire;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  assign wr_pal      = wr_addr[PAL_SELECT_BIT];
  assign rd_pal      = rd_addr[PAL_SELECT_BIT];
  assign wr_vram_idx = wr_addr[WORD_LSB +: VRAM_INDEX_W];
  assign rd_vram_idx = rd_addr[WORD_LSB +: VRAM_INDEX_W];
  assign wr_pal_idx  = wr_addr[WORD_LSB +: PAL_INDEX_W];
  assign rd_pal_idx  = rd_addr[WORD_LSB +: PAL_INDEX_W];

  // req high with ack still low is the first cycle of a request
  assign wr_fire = wr_req && !wr_ack;
  assign rd_fire = rd_req && !rd_ack;

  ////////////////////////////////////////
  // ack handshakes
  ////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end
    else
    begin
      // ack one cycle after req, release one cycle after req drops
      if (wr_fire)
        wr_ack <= 1'b1;
      else if (!wr_req)
        wr_ack <= 1'b0;
      if (rd_fire)
        rd_ack <= 1'b1;
      else if (!rd_req)
        rd_ack <= 1'b0;
    end
  end

  // vram starts out blank
  initial
  begin
    for (int i = 0; i < VRAM_DEPTH; i++)
      vram[i] = '0;
  end

  // byte merge into vram, upper index bits drop for small depths
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wr_fire && !wr_pal)
      for (int b = 0; b < AXI_STRB_W; b++)
        if (wr_strb[b])
          vram[wr_vram_idx[VRAM_AW-1:0]][b*8 +: 8] <= wr_data[b*8 +: 8];
  end

  // palette registers, same byte merge
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < PAL_ENTRIES; i++)
        palette[i] <= '0;
    end
    else if (wr_fire && wr_pal)
    begin
      for (int b = 0; b < AXI_STRB_W; b++)
        if (wr_strb[b])
          palette[wr_pal_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
    end
  end

  // read word registered once per request, held until req falls
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (rd_fire)
      rd_data <= rd_pal ? palette[rd_pal_idx] : vram[rd_vram_idx[VRAM_AW-1:0]];
  end

  // ack is only ever an answer to a request
  a_wr_ack_needs_req: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(wr_ack) |-> $past(wr_req))
    else $error("wr_ack rose with no wr_req");

endmodule

`default_nettype wire

//--- verilog/text_ctrl_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module text_ctrl_axi_top
  import axi_lite_pkg::*;
#(
  parameter int VRAM_DEPTH = 1024
)
(
  input  wire             S_AXI_ACLK,
  input  wire             S_AXI_ARESETN,
  // write address and data
  input  wire  axi_addr_t S_AXI_AWADDR,
  input  wire             S_AXI_AWVALID,
  output logic            S_AXI_AWREADY,
  input  wire  axi_data_t S_AXI_WDATA,
  input  wire  axi_strb_t S_AXI_WSTRB,
  input  wire             S_AXI_WVALID,
  output logic            S_AXI_WREADY,
  // write response
  output axi_resp_t       S_AXI_BRESP,
  output logic            S_AXI_BVALID,
  input  wire             S_AXI_BREADY,
  // read address
  input  wire  axi_addr_t S_AXI_ARADDR,
  input  wire             S_AXI_ARVALID,
  output logic            S_AXI_ARREADY,
  // read data
  output axi_data_t       S_AXI_RDATA,
  output axi_resp_t       S_AXI_RRESP,
  output logic            S_AXI_RVALID,
  input  wire             S_AXI_RREADY
);

  ////////////////////////////////////////
  // channel to store links
  ////////////////////////////////////////

  logic      wr_req;
  logic      wr_ack;
  axi_addr_t wr_addr;
  axi_data_t wr_data;
  axi_strb_t wr_strb;
  logic      rd_req;
  logic      rd_ack;
  axi_addr_t rd_addr;
  axi_data_t rd_data;

  // producer of store writes
  axi_write_channel u_wr (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .wr_ack        (wr_ack)
  );

  // vram and palette
  text_vram_store #(.VRAM_DEPTH(VRAM_DEPTH)) u_store (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .wr_ack        (wr_ack),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_ack        (rd_ack),
    .rd_data       (rd_data)
  );

  // consumer, turns stored words into R beats
  axi_read_channel u_rd (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .rd_ack        (rd_ack),
    .rd_data       (rd_data)
  );

endmodule

`default_nettype wire

//--- tb/tb_text_ctrl_table.svh
`ifndef TB_TEXT_CTRL_TABLE_SVH
`define TB_TEXT_CTRL_TABLE_SVH

// columns: op, address, write data, write strobes, expected read data
// write rows leave the last column at zero, read rows the data and strobes

localparam logic OP_WR = 1'b0;
localparam logic OP_RD = 1'b1;

typedef struct packed {
  logic        op;
  logic [15:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
  logic [31:0] exp_data;
} row_t;

localparam int NUM_ROWS = 23;

row_t table_rows [NUM_ROWS] = '{
  // blank vram and palette after reset
  '{OP_RD, 16'h0000, 32'h0000_0000, 4'h0, 32'h0000_0000},
  '{OP_RD, 16'h8000, 32'h0000_0000, 4'h0, 32'h0000_0000},
  '{OP_RD, 16'h0ffc, 32'h0000_0000, 4'h0, 32'h0000_0000},
  '{OP_RD, 16'h801c, 32'h0000_0000, 4'h0, 32'h0000_0000},
  // full word, then byte lanes 0 and 2, then lane 3
  '{OP_WR, 16'h0010, 32'hdead_beef, 4'hf, 32'h0000_0000},
  '{OP_RD, 16'h0010, 32'h0000_0000, 4'h0, 32'hdead_beef},
  '{OP_WR, 16'h0010, 32'h1122_3344, 4'h5, 32'h0000_0000},
  '{OP_RD, 16'h0010, 32'h0000_0000, 4'h0, 32'hde22_be44},
  '{OP_WR, 16'h0010, 32'ha5a5_a5a5, 4'h8, 32'h0000_0000},
  '{OP_RD, 16'h0010, 32'h0000_0000, 4'h0, 32'ha522_be44},
  // palette entry 4 next to vram word 4
  '{OP_WR, 16'h8010, 32'h00ff_8800, 4'hf, 32'h0000_0000},
  '{OP_RD, 16'h0010, 32'h0000_0000, 4'h0, 32'ha522_be44},
  '{OP_RD, 16'h8010, 32'h0000_0000, 4'h0, 32'h00ff_8800},
  // vram word 5 leaves palette entry 5 alone
  '{OP_WR, 16'h0014, 32'h1234_5678, 4'hf, 32'h0000_0000},
  '{OP_RD, 16'h8014, 32'h0000_0000, 4'h0, 32'h0000_0000},
  '{OP_RD, 16'h0014, 32'h0000_0000, 4'h0, 32'h1234_5678},
  // byte merge on a palette entry
  '{OP_WR, 16'h8010, 32'h0000_00cc, 4'h1, 32'h0000_0000},
  '{OP_RD, 16'h8010, 32'h0000_0000, 4'h0, 32'h00ff_88cc},
  // bits 12 to 14 alias onto word 8
  '{OP_WR, 16'h7020, 32'hcafe_f00d, 4'hf, 32'h0000_0000},
  '{OP_RD, 16'h0020, 32'h0000_0000, 4'h0, 32'hcafe_f00d},
  '{OP_RD, 16'h3020, 32'h0000_0000, 4'h0, 32'hcafe_f00d},
  '{OP_WR, 16'h5020, 32'h0000_aa00, 4'h2, 32'h0000_0000},
  '{OP_RD, 16'h7020, 32'h0000_0000, 4'h0, 32'hcafe_aa0d}
};

`endif

//--- tb/tb_text_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_text_ctrl;

  `include "tb_text_ctrl_table.svh"

  localparam int CLK_PERIOD = 4;
  localparam int NUM_RAND   = 32;
  // 40 cycles per row, a few more for reset
  localparam int WATCHDOG_NS = ((NUM_ROWS + NUM_RAND) * 40 + 10) * CLK_PERIOD;
  localparam logic [1:0] OKAY = 2'b00;

  logic        clk;
  logic        aresetn;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // shadow copy of vram and palette
  logic [31:0] shadow_vram [1024];
  logic [31:0] shadow_pal [8];
  logic [31:0] rng_state = 32'd35992;

  text_ctrl_axi_top #(.VRAM_DEPTH(1024)) DUT (
    .S_AXI_ACLK    (clk),
    .S_AXI_ARESETN (aresetn),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready)
  );

  // 4 ns period
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("** Error: [%0t] %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // 0 to 7 cycles of back-pressure
  function automatic int draw_delay();
    logic [31:0] r;
    r = next_random();
    return int'(r[2:0]);
  endfunction

  // bit 15 and the alias bits random, vram words 0 to 15
  function automatic logic [15:0] pick_address(input logic [31:0] r);
    return {r[15:12], 6'b000000, r[5:2], 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        result[b*8 +: 8] = new_word[b*8 +: 8];
    return result;
  endfunction

  // palette index addr[4:2], vram index addr[11:2]
  task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr[15])
      shadow_pal[addr[4:2]] = merge_bytes(shadow_pal[addr[4:2]], data, strb);
    else
      shadow_vram[addr[11:2]] = merge_bytes(shadow_vram[addr[11:2]], data, strb);
  endtask

  function automatic logic [31:0] model_read(input logic [15:0] addr);
    return addr[15] ? shadow_pal[addr[4:2]] : shadow_vram[addr[11:2]];
  endfunction

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int hold;
    hold = draw_delay();
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    // ready seen here, handshake on the next rising edge
    @(negedge clk);
    while (!awready)
      @(negedge clk);
    assert (wready) else stop_on_error("WREADY did not pulse with AWREADY");
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
      @(negedge clk);
    // B held back, must stay up
    repeat (hold)
    begin
      @(negedge clk);
      assert (bvalid) else stop_on_error("BVALID dropped before BREADY");
    end
    assert (bresp === OKAY)
      else stop_on_error($sformatf("BRESP %0h at %h, expected OKAY", bresp, addr));
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    assert (!bvalid) else stop_on_error("BVALID still high after BREADY");
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
    int          hold;
    logic [31:0] first;
    hold = draw_delay();
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge clk);
    first = rdata;
    // beat frozen until RREADY
    repeat (hold)
    begin
      @(negedge clk);
      assert (rvalid && rdata === first) else stop_on_error("R beat changed before RREADY");
    end
    assert (rresp === OKAY)
      else stop_on_error($sformatf("RRESP %0h at %h, expected OKAY", rresp, addr));
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    assert (!rvalid) else stop_on_error("RVALID still high after RREADY");
    data = first;
  endtask

  task automatic check_read(input logic [15:0] addr, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("read %h returned %h, expected %h", addr, got, exp));
  endtask

  task automatic run_row(input row_t row);
    logic [31:0] got;
    if (row.op == OP_WR)
    begin
      bus_write(row.addr, row.data, row.strb);
      model_write(row.addr, row.data, row.strb);
    end
    else
    begin
      bus_read(row.addr, got);
      check_read(row.addr, got, row.exp_data);
    end
  endtask

  // one random write, then a read checked against the shadow copy
  task automatic run_random_row();
    logic [15:0] waddr;
    logic [15:0] raddr;
    logic [31:0] data;
    logic [31:0] strb_bits;
    logic [31:0] got;
    waddr     = pick_address(next_random());
    data      = next_random();
    strb_bits = next_random();
    bus_write(waddr, data, strb_bits[3:0]);
    model_write(waddr, data, strb_bits[3:0]);
    raddr = pick_address(next_random());
    bus_read(raddr, got);
    check_read(raddr, got, model_read(raddr));
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    clk     = 1'b0;
    aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 1024; i++)
      shadow_vram[i] = '0;
    for (int i = 0; i < 8; i++)
      shadow_pal[i] = '0;
    repeat (5) @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);
    assert (!awready && !wready && !bvalid && !arready && !rvalid)
      else stop_on_error("handshake outputs not low after reset");
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(table_rows[i]);
    for (int i = 0; i < NUM_RAND; i++)
      run_random_row();
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: bus transfers still running after %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+tb
verilog/axi_lite_pkg.sv
verilog/text_map_pkg.sv
verilog/axi_write_channel.sv
verilog/axi_read_channel.sv
verilog/text_vram_store.sv
verilog/text_ctrl_axi_top.sv
tb/tb_text_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build the text controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_text_ctrl -f files.f -o tb_text_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_text_ctrl_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
